/* Makefile */
SIM := obj_dir/Vtb_img_controller

.PHONY: all run clean

all: run

$(SIM): compile.f $(wildcard hdl/*.sv verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_img_controller -f compile.f -o Vtb_img_controller

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -qx "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
hdl/img_pkg.sv
hdl/frame_buffer.sv
hdl/img_capture.sv
hdl/fletcher_checksum.sv
hdl/readout_ctrl.sv
hdl/img_controller.sv
verification/img_clock_gen.sv
verification/img_controller_assertions.sv
verification/tb_img_controller.sv

/* hdl/fletcher_checksum.sv */
module fletcher_checksum (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear,
    input  logic                          en,
    input  logic [img_pkg::WORD_W-1:0]    din,
    output logic [2*img_pkg::WORD_W-1:0]  sum
);

    logic [15:0] sum_lo;
    logic [15:0] sum_hi;
    logic [15:0] lo_next;

    // Addition modulo 65535 of two values below 65536
    function automatic logic [15:0] add_mod(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    assign lo_next = add_mod(sum_lo, din);
    assign sum     = {sum_hi, sum_lo};

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            sum_lo <= 16'd0;
            sum_hi <= 16'd0;
        end else if (en) begin
            sum_lo <= lo_next;
            sum_hi <= add_mod(sum_hi, lo_next);
        end
    end

endmodule

/* hdl/frame_buffer.sv */
module frame_buffer (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [img_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [img_pkg::WORD_W-1:0]  wr_data,
    input  logic                        rd_en,
    input  logic [img_pkg::ADDR_W-1:0]  rd_addr,
    output logic [img_pkg::WORD_W-1:0]  rd_data
);

    // One word per pixel, in raster order
    logic [img_pkg::WORD_W-1:0] mem [img_pkg::PIXEL_COUNT];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data follows rd_en by one cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* hdl/img_capture.sv */
module img_capture (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_capture,
    input  logic                         cmd_skip,
    input  logic                         img_fv,
    input  logic                         img_lv,
    input  logic [img_pkg::PIXEL_W-1:0]  img_d,
    output logic                         wr_en,
    output logic [img_pkg::ADDR_W-1:0]   wr_addr,
    output logic [img_pkg::WORD_W-1:0]   wr_data,
    output logic                         capture_done,
    output logic [img_pkg::COUNT_W-1:0]  pixel_count,
    output logic [img_pkg::STAT_W-1:0]   highlight_count,
    output logic [img_pkg::STAT_W-1:0]   shadow_count
);

    img_pkg::capture_state_t state;

    logic                        fv_prev;
    logic                        lv_prev;
    logic [1:0]                  x_pos;
    logic [1:0]                  y_pos;
    logic                        skip_left;
    logic                        stat_en;
    logic [img_pkg::PIXEL_W-1:0] stat_px;
    logic                        frame_start;
    logic                        buf_full;
    logic                        store_px;

    assign frame_start = img_fv && !fv_prev;
    assign buf_full    = (pixel_count == img_pkg::COUNT_W'(img_pkg::PIXEL_COUNT));
    assign store_px    = (state == img_pkg::CAP_STORE) && img_lv && !buf_full;

    // ========================================
    // Sensor timing tracking
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            x_pos   <= 2'd0;
            y_pos   <= 2'd0;
        end else begin
            fv_prev <= img_fv;
            lv_prev <= img_lv;
            // Both positions wrap mod 4 for the statistics grid
            x_pos <= img_lv ? x_pos + 2'd1 : 2'd0;
            if (!img_fv) begin
                y_pos <= 2'd0;
            end else if (lv_prev && !img_lv) begin
                y_pos <= y_pos + 2'd1;
            end
        end
    end

    // ========================================
    // Capture FSM and counters
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= img_pkg::CAP_IDLE;
            skip_left       <= 1'b0;
            wr_en           <= 1'b0;
            stat_en         <= 1'b0;
            capture_done    <= 1'b0;
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            capture_done <= 1'b0;
            wr_en        <= store_px;
            stat_en      <= store_px && (x_pos == 2'd0) && (y_pos == 2'd0);

            if (store_px) begin
                pixel_count <= pixel_count + 1'b1;
            end

            // Sampled pixel is judged one cycle later on its top 7 bits
            if (stat_en) begin
                if (&stat_px[11:5]) begin
                    highlight_count <= highlight_count + 1'b1;
                end else if (~|stat_px[11:5]) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end

            case (state)
                img_pkg::CAP_IDLE: begin
                    if (cmd_capture) begin
                        pixel_count     <= '0;
                        highlight_count <= '0;
                        shadow_count    <= '0;
                        skip_left       <= cmd_skip;
                        state           <= img_pkg::CAP_WAIT_FRAME;
                    end
                end
                img_pkg::CAP_WAIT_FRAME: begin
                    if (frame_start) begin
                        state <= img_pkg::CAP_CHECK_SKIP;
                    end
                end
                img_pkg::CAP_CHECK_SKIP: begin
                    skip_left <= 1'b0;
                    state     <= skip_left ? img_pkg::CAP_WAIT_FRAME : img_pkg::CAP_STORE;
                end
                img_pkg::CAP_STORE: begin
                    if (!img_fv) begin
                        capture_done <= 1'b1;
                        state        <= img_pkg::CAP_IDLE;
                    end
                end
                default: state <= img_pkg::CAP_IDLE;
            endcase
        end
    end

    // Buffer word is low byte first, then the top nibble
    always_ff @(posedge clk) begin
        wr_addr <= pixel_count[img_pkg::ADDR_W-1:0];
        wr_data <= {img_d[7:0], 4'b0000, img_d[11:8]};
        stat_px <= img_d;
    end

endmodule

/* hdl/img_controller.sv */
module img_controller (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          cmd_capture,
    input  logic                                          cmd_skip,
    input  logic                                          cmd_readout,
    input  logic [img_pkg::HEADER_WORDS*img_pkg::WORD_W-1:0] cmd_header,
    input  logic                                          cmd_thumb,
    input  logic                                          img_fv,
    input  logic                                          img_lv,
    input  logic [img_pkg::PIXEL_W-1:0]                   img_d,
    input  logic                                          readout_trigger,
    output logic                                          capture_done,
    output logic [img_pkg::COUNT_W-1:0]                   pixel_count,
    output logic [img_pkg::STAT_W-1:0]                    highlight_count,
    output logic [img_pkg::STAT_W-1:0]                    shadow_count,
    output logic                                          readout_start,
    output logic                                          readout_ready,
    output logic [img_pkg::WORD_W-1:0]                    readout_data
);

    // Buffer write side
    logic                        wr_en;
    logic [img_pkg::ADDR_W-1:0]  wr_addr;
    logic [img_pkg::WORD_W-1:0]  wr_data;

    // Buffer read side
    logic                        rd_en;
    logic [img_pkg::ADDR_W-1:0]  rd_addr;
    logic [img_pkg::WORD_W-1:0]  rd_data;

    // Checksum
    logic                          ck_clear;
    logic                          ck_en;
    logic [img_pkg::WORD_W-1:0]    ck_din;
    logic [2*img_pkg::WORD_W-1:0]  ck_sum;

    img_capture i_img_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_capture     (cmd_capture),
        .cmd_skip        (cmd_skip),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .img_d           (img_d),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .capture_done    (capture_done),
        .pixel_count     (pixel_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    frame_buffer i_frame_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fletcher_checksum i_fletcher_checksum (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (ck_clear),
        .en    (ck_en),
        .din   (ck_din),
        .sum   (ck_sum)
    );

    readout_ctrl i_readout_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .rd_data         (rd_data),
        .sum             (ck_sum),
        .readout_trigger (readout_trigger),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .ck_clear        (ck_clear),
        .ck_en           (ck_en),
        .ck_din          (ck_din),
        .readout_start   (readout_start),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data)
    );

endmodule

/* hdl/img_pkg.sv */
package img_pkg;

    // ========================================
    // Image geometry
    // ========================================
    localparam int IMG_WIDTH   = 16;
    localparam int IMG_HEIGHT  = 8;
    localparam int PIXEL_COUNT = IMG_WIDTH * IMG_HEIGHT;

    localparam int ADDR_W  = $clog2(PIXEL_COUNT);
    localparam int COUNT_W = ADDR_W + 1;
    localparam int STAT_W  = 8;
    localparam int PIXEL_W = 12;
    localparam int WORD_W  = 16;

    // ========================================
    // Readout stream layout
    // ========================================
    localparam int HEADER_WORDS   = 4;
    localparam int CHECKSUM_WORDS = 2;
    localparam int PADDING_WORDS  = 2;
    localparam int TAIL_WORDS     = CHECKSUM_WORDS + PADDING_WORDS;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_FRAME,
        CAP_CHECK_SKIP,
        CAP_STORE
    } capture_state_t;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_HEADER,
        RD_PIXELS,
        RD_DRAIN,
        RD_TAIL
    } readout_state_t;

endpackage

/* hdl/readout_ctrl.sv */
module readout_ctrl (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          cmd_readout,
    input  logic [img_pkg::HEADER_WORDS*img_pkg::WORD_W-1:0] cmd_header,
    input  logic                                          cmd_thumb,
    input  logic [img_pkg::WORD_W-1:0]                    rd_data,
    input  logic [2*img_pkg::WORD_W-1:0]                  sum,
    input  logic                                          readout_trigger,
    output logic                                          rd_en,
    output logic [img_pkg::ADDR_W-1:0]                    rd_addr,
    output logic                                          ck_clear,
    output logic                                          ck_en,
    output logic [img_pkg::WORD_W-1:0]                    ck_din,
    output logic                                          readout_start,
    output logic                                          readout_ready,
    output logic [img_pkg::WORD_W-1:0]                    readout_data
);

    img_pkg::readout_state_t state;

    logic [img_pkg::HEADER_WORDS*img_pkg::WORD_W-1:0] shift_reg;
    logic [2:0]                  word_cnt;
    logic                        thumb;
    logic                        rd_pend;
    logic                        skid_valid;
    logic [img_pkg::WORD_W-1:0]  skid_data;
    logic                        xfer;
    logic                        load;
    logic                        keep;
    logic                        space;
    logic [1:0]                  occupancy;

    // Output register is free, or is emptied on this edge
    assign xfer = readout_ready && readout_trigger;
    assign load = !readout_ready || readout_trigger;

    // Column is rd_addr[3:0], row is rd_addr[6:4]
    assign keep = !thumb || ((rd_addr[2:1] == 2'b00) && (rd_addr[6:5] == 2'b00));

    // Words held or arriving, against the output register plus the skid
    assign occupancy = {1'b0, readout_ready} + {1'b0, skid_valid} + {1'b0, rd_pend};
    assign space     = (occupancy <= (xfer ? 2'd2 : 2'd1));
    assign rd_en     = (state == img_pkg::RD_PIXELS) && keep && space;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= img_pkg::RD_IDLE;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
            ck_clear      <= 1'b0;
            ck_en         <= 1'b0;
            rd_pend       <= 1'b0;
            skid_valid    <= 1'b0;
            word_cnt      <= 3'd0;
            thumb         <= 1'b0;
            rd_addr       <= '0;
        end else begin
            readout_start <= 1'b0;
            ck_clear      <= 1'b0;
            rd_pend       <= rd_en;
            // Header and pixel words go into the checksum, the tail does not
            ck_en <= xfer && (state != img_pkg::RD_TAIL);

            case (state)
                img_pkg::RD_IDLE: begin
                    if (cmd_readout) begin
                        readout_start <= 1'b1;
                        ck_clear      <= 1'b1;
                        thumb         <= cmd_thumb;
                        rd_addr       <= '0;
                        skid_valid    <= 1'b0;
                        word_cnt      <= 3'(img_pkg::HEADER_WORDS);
                        state         <= img_pkg::RD_HEADER;
                    end
                end
                img_pkg::RD_HEADER, img_pkg::RD_TAIL: begin
                    if (load) begin
                        if (word_cnt != 3'd0) begin
                            readout_ready <= 1'b1;
                            word_cnt      <= word_cnt - 3'd1;
                        end else begin
                            readout_ready <= 1'b0;
                            state <= (state == img_pkg::RD_HEADER) ? img_pkg::RD_PIXELS
                                                                   : img_pkg::RD_IDLE;
                        end
                    end
                end
                img_pkg::RD_PIXELS, img_pkg::RD_DRAIN: begin
                    // Refill the output from the skid first, then from the buffer
                    if (load) begin
                        readout_ready <= skid_valid || rd_pend;
                        skid_valid    <= skid_valid && rd_pend;
                    end else begin
                        skid_valid <= skid_valid || rd_pend;
                    end

                    if (state == img_pkg::RD_PIXELS && (!keep || space)) begin
                        rd_addr <= rd_addr + 1'b1;
                        if (&rd_addr) begin
                            state <= img_pkg::RD_DRAIN;
                        end
                    end

                    // Everything sent and the last checksum update landed
                    if (state == img_pkg::RD_DRAIN && !rd_pend && !skid_valid &&
                        !readout_ready && !ck_en) begin
                        word_cnt <= 3'(img_pkg::TAIL_WORDS);
                        state    <= img_pkg::RD_TAIL;
                    end
                end
                default: state <= img_pkg::RD_IDLE;
            endcase
        end
    end

    // ========================================
    // Data path
    // ========================================
    always_ff @(posedge clk) begin
        ck_din <= {readout_data[7:0], readout_data[15:8]};

        case (state)
            img_pkg::RD_IDLE: begin
                shift_reg <= cmd_header;
            end
            img_pkg::RD_HEADER, img_pkg::RD_TAIL: begin
                if (load && word_cnt != 3'd0) begin
                    readout_data <= shift_reg[$bits(shift_reg)-1 -: img_pkg::WORD_W];
                    shift_reg    <= shift_reg << img_pkg::WORD_W;
                end
            end
            img_pkg::RD_PIXELS, img_pkg::RD_DRAIN: begin
                if (load) begin
                    if (skid_valid) begin
                        readout_data <= skid_data;
                    end else if (rd_pend) begin
                        readout_data <= rd_data;
                    end
                end
                if (load || !skid_valid) begin
                    skid_data <= rd_data;
                end
                // Little-endian checksum words, then the zero padding
                shift_reg <= {sum[7:0], sum[15:8], sum[23:16], sum[31:24],
                              {img_pkg::PADDING_WORDS*img_pkg::WORD_W{1'b0}}};
            end
            default: begin
            end
        endcase
    end

endmodule

/* verification/img_clock_gen.sv */
module img_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ns;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over 5 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verification/img_controller_assertions.sv */
module img_controller_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        capture_done,
    input logic                        readout_start,
    input logic                        readout_ready,
    input logic                        readout_trigger,
    input logic [img_pkg::WORD_W-1:0]  readout_data
);
    timeunit 1ns;
    timeprecision 1ns;

    // A stalled word stays on the bus until the host takes it
    property data_held_p;
        @(posedge clk) disable iff (!rst_n)
            (readout_ready && !readout_trigger) |=> $stable(readout_data);
    endproperty

    data_held_a: assert property (data_held_p)
        else $error("readout_data changed while readout_ready was high without trigger");

    // No word is offered while in reset
    reset_ready_a: assert property (@(posedge clk) !rst_n |=> !readout_ready)
        else $error("readout_ready high during reset");

    capture_done_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n) capture_done |=> !capture_done)
        else $error("capture_done high for more than one cycle");

    readout_start_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n) readout_start |=> !readout_start)
        else $error("readout_start high for more than one cycle");

endmodule

/* verification/tb_img_controller.sv */
module tb_img_controller;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_TESTS  = 5;
    localparam int WAIT_LIMIT = 200;
    localparam int W          = img_pkg::IMG_WIDTH;

    typedef struct packed {
        logic        skip;
        logic        thumb;
        logic [63:0] header;
        logic [11:0] seed;
        logic        random_trig;
        logic [7:0]  exp_count;
    } test_entry_t;

    logic        clk;
    logic        rst_n;
    logic        cmd_capture;
    logic        cmd_skip;
    logic        cmd_readout;
    logic [63:0] cmd_header;
    logic        cmd_thumb;
    logic        img_fv;
    logic        img_lv;
    logic [11:0] img_d;
    logic        readout_trigger;
    logic        capture_done;
    logic [7:0]  pixel_count;
    logic [7:0]  highlight_count;
    logic [7:0]  shadow_count;
    logic        readout_start;
    logic        readout_ready;
    logic [15:0] readout_data;

    test_entry_t tests [NUM_TESTS];
    logic [15:0] exp_words [$];
    logic [15:0] got_words [$];
    int          exp_high;
    int          exp_shadow;
    int          errors = 0;
    bit          timed_out = 1'b0;

    img_clock_gen i_img_clock_gen (.clk(clk), .rst_n(rst_n));

    img_controller i_img_controller (.*);

    bind img_controller img_controller_assertions i_img_controller_assertions (
        .clk(clk), .rst_n(rst_n), .capture_done(capture_done),
        .readout_start(readout_start), .readout_ready(readout_ready),
        .readout_trigger(readout_trigger), .readout_data(readout_data)
    );

    // ========================================
    // Reference model
    // ========================================
    // Sampled columns get forced highlight or shadow values in turn
    function automatic logic [11:0] pixel_value(input logic [11:0] seed, input int idx);
        logic [11:0] p;
        p = 12'(idx * 149) ^ seed;
        if (idx % 4 == 0) begin
            case ((idx / 4 + int'(seed)) % 3)
                0: p = p | 12'hFE0;
                1: p = p & 12'h01F;
                default: ;
            endcase
        end
        return p;
    endfunction

    task automatic build_expected(input logic [11:0] seed, input logic thumb,
                                  input logic [63:0] header);
        int          idx;
        int          lo = 0;
        int          hi = 0;
        logic [11:0] p;
        logic [31:0] s;
        exp_words.delete();
        exp_high   = 0;
        exp_shadow = 0;
        for (idx = 0; idx < img_pkg::HEADER_WORDS; idx++) begin
            exp_words.push_back(header[63-16*idx -: 16]);
        end
        for (idx = 0; idx < img_pkg::PIXEL_COUNT; idx++) begin
            p = pixel_value(seed, idx);
            if ((idx / W) % 4 == 0 && (idx % W) % 4 == 0) begin
                if (p[11:5] == 7'h7F) exp_high++;
                else if (p[11:5] == 7'h00) exp_shadow++;
            end
            if (!thumb || ((idx % W) % 8 < 2 && (idx / W) % 8 < 2)) begin
                exp_words.push_back({p[7:0], 4'h0, p[11:8]});
            end
        end
        // Fletcher-32 over the byte-swapped header and pixel words
        foreach (exp_words[idx]) begin
            lo = (lo + int'({exp_words[idx][7:0], exp_words[idx][15:8]})) % 65535;
            hi = (hi + lo) % 65535;
        end
        s = {hi[15:0], lo[15:0]};
        exp_words.push_back({s[7:0], s[15:8]});
        exp_words.push_back({s[23:16], s[31:24]});
        exp_words.push_back(16'h0000);
        exp_words.push_back(16'h0000);
    endtask

    // ========================================
    // Sensor, host and checker
    // ========================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic drive_frame(input logic [11:0] seed);
        int row;
        int col;
        @(negedge clk);
        img_fv = 1'b1;
        repeat (3) @(negedge clk);
        for (row = 0; row < img_pkg::IMG_HEIGHT; row++) begin
            for (col = 0; col < W; col++) begin
                img_lv = 1'b1;
                img_d  = pixel_value(seed, row * W + col);
                @(negedge clk);
            end
            // Line gap
            img_lv = 1'b0;
            img_d  = 12'h000;
            repeat (2) @(negedge clk);
        end
        img_fv = 1'b0;
    endtask

    task automatic wait_capture_done();
        int waited = 0;
        bit seen = 1'b0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            seen = capture_done;
            waited++;
        end
        if (!seen) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: capture_done did not pulse within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // A word counts as taken when ready and trigger meet at the next rising edge
    task automatic collect_stream(input logic random_trig, input int n_words);
        int   w;
        int   waited;
        bit   took;
        logic trig;
        got_words.delete();
        for (w = 0; w < n_words && !timed_out; w++) begin
            waited = 0;
            took   = 1'b0;
            while (!took && waited < WAIT_LIMIT) begin
                @(negedge clk);
                trig = random_trig ? 1'($urandom_range(1, 0)) : 1'b1;
                readout_trigger = trig;
                if (readout_ready && trig) begin
                    got_words.push_back(readout_data);
                    took = 1'b1;
                end
                waited++;
            end
            if (!took) begin
                errors++;
                timed_out = 1'b1;
                $display("Timeout: readout word %0d never became ready", w);
            end
        end
        @(negedge clk);
        readout_trigger = 1'b0;
    endtask

    task automatic run_entry(input test_entry_t e);
        int i;
        build_expected(e.seed, e.thumb, e.header);
        @(negedge clk);
        cmd_capture = 1'b1;
        cmd_skip    = e.skip;
        @(negedge clk);
        cmd_capture = 1'b0;
        cmd_skip    = 1'b0;
        if (e.skip) begin
            drive_frame(e.seed ^ 12'hA5A);
            repeat (3) @(negedge clk);
        end
        drive_frame(e.seed);
        wait_capture_done();
        if (timed_out) return;
        check_value("pixel_count", 32'(pixel_count), 32'(e.exp_count));
        check_value("highlight_count", 32'(highlight_count), 32'(exp_high));
        check_value("shadow_count", 32'(shadow_count), 32'(exp_shadow));

        @(negedge clk);
        cmd_readout = 1'b1;
        cmd_header  = e.header;
        cmd_thumb   = e.thumb;
        @(negedge clk);
        cmd_readout = 1'b0;
        check_value("readout_start", 32'(readout_start), 32'd1);
        collect_stream(e.random_trig, exp_words.size());
        if (timed_out) return;
        for (i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
            check_value($sformatf("readout_data[%0d]", i), 32'(got_words[i]),
                        32'(exp_words[i]));
        end
        // End of stream, ready stays low
        repeat (3) begin
            @(negedge clk);
            check_value("readout_ready", 32'(readout_ready), 32'd0);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int waited = 0;
        int t;
        cmd_capture     = 1'b0;
        cmd_skip        = 1'b0;
        cmd_readout     = 1'b0;
        cmd_header      = 64'h0;
        cmd_thumb       = 1'b0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        img_d           = 12'h000;
        readout_trigger = 1'b0;
        void'($urandom(32'h6afb));

        // skip, thumb, header, seed, random trigger, expected pixel_count
        tests[0] = '{1'b0, 1'b0, 64'h4652_414D_0010_0008, 12'h3A5, 1'b0, 8'd128};
        tests[1] = '{1'b0, 1'b0, 64'h4652_414D_0010_0008, 12'h3A5, 1'b1, 8'd128};
        tests[2] = '{1'b1, 1'b0, 64'h1234_5678_9ABC_DEF0, 12'h0C7, 1'b1, 8'd128};
        tests[3] = '{1'b0, 1'b1, 64'hFFFF_0000_00FF_FF00, 12'h5E1, 1'b0, 8'd128};
        tests[4] = '{1'b1, 1'b1, 64'hC0DE_0001_BEEF_0002, 12'h71B, 1'b1, 8'd128};

        while (!rst_n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rst_n) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: reset was never released");
        end else begin
            @(negedge clk);
            check_value("capture_done", 32'(capture_done), 32'd0);
            check_value("readout_start", 32'(readout_start), 32'd0);
            check_value("readout_ready", 32'(readout_ready), 32'd0);
            check_value("pixel_count", 32'(pixel_count), 32'd0);
            check_value("highlight_count", 32'(highlight_count), 32'd0);
            check_value("shadow_count", 32'(shadow_count), 32'd0);
        end

        for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_entry(tests[t]);
        end

        $display("Simulation finished with %0d errors over %0d table entries",
                 errors, NUM_TESTS);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
